//--- verilog/mem_ss_param_pkg.sv
// memory subsystem sizes, latencies and the address map shared by the RTL and the testbench
package mem_ss_param_pkg;

   // word address and data widths
   localparam int ADDR_W = 20;
   localparam int DATA_W = 32;

   localparam int FIFO_DEPTH = 4;    // entries in each agent's request FIFO

   // behavioural SRAM geometry and read pipeline depth
   localparam int SRAM_WORDS  = 256;
   localparam int SRAM_RD_LAT = 2;

   // instruction side owns the lower 64K words, top bound excluded
   localparam logic [ADDR_W-1:0] I_BASE = 20'h00000;
   localparam logic [ADDR_W-1:0] I_TOP  = 20'h10000;

   // data side owns the next 64K words
   localparam logic [ADDR_W-1:0] D_BASE = 20'h10000;
   localparam logic [ADDR_W-1:0] D_TOP  = 20'h20000;

endpackage

//--- verilog/mem_ss_req_pkg.sv
// request encoding for the memory subsystem: opcode values and agent numbering
package mem_ss_req_pkg;

   // values carried on the one-bit write field of a request
   localparam logic OP_READ  = 1'b0;
   localparam logic OP_WRITE = 1'b1;

   // client slots on the controller's round-robin arbiter
   localparam int AGENT_I = 0;    // instruction cache side
   localparam int AGENT_D = 1;    // data cache side

   localparam int NUM_AGENTS = 2;

endpackage

//--- verilog/fm_req_if.sv
// request bundle between a sender and the memory controller or SRAM (valid, write, address, data)
`timescale 1ns/100ps

interface fm_req_if;

   logic                                valid;    // request is taken in the cycle this is high
   logic                                write;    // see mem_ss_req_pkg for the encoding
   logic [mem_ss_param_pkg::ADDR_W-1:0] addr;
   logic [mem_ss_param_pkg::DATA_W-1:0] data;     // don't care on reads

   // the side that launches requests
   modport sender (
      output valid,
      output write,
      output addr,
      output data
   );

   // the side that consumes them, there is no acceptance signal back
   modport receiver (
      input valid,
      input write,
      input addr,
      input data
   );

endinterface

//--- verilog/fifo.sv
// show-ahead synchronous FIFO with full and empty flags, head word visible before pop
`timescale 1ns/100ps

module fifo #(
   parameter int DATA_W = mem_ss_param_pkg::DATA_W,
   parameter int DEPTH  = mem_ss_param_pkg::FIFO_DEPTH
) (
   input  logic              clk,
   input  logic              i_rst,
   input  logic              i_push,
   input  logic [DATA_W-1:0] i_push_data,
   input  logic              i_pop,
   output logic [DATA_W-1:0] o_pop_data,
   output logic              o_full,
   output logic              o_empty
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [DATA_W-1:0] mem [DEPTH];
   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   logic [CNT_W-1:0]  count;
   logic              push_ok;
   logic              pop_ok;

   // pointers wrap explicitly so that depths other than a power of two work too
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      ptr_inc = (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign o_full     = (count == CNT_W'(DEPTH));
   assign o_empty    = (count == '0);
   assign push_ok    = i_push & ~o_full;    // a push into a full FIFO is lost
   assign pop_ok     = i_pop & ~o_empty;
   assign o_pop_data = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (push_ok) begin
         mem[wr_ptr] <= i_push_data;
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push_ok) wr_ptr <= ptr_inc(wr_ptr);
         if (pop_ok)  rd_ptr <= ptr_inc(rd_ptr);
         // simultaneous push and pop leave the occupancy unchanged
         case ({push_ok, pop_ok})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

//--- verilog/arbiter.sv
// round-robin arbiter, one-hot grant among the valid candidates each cycle
`timescale 1ns/100ps

module arbiter #(
   parameter int NUM_CLIENTS = mem_ss_req_pkg::NUM_AGENTS
) (
   input  logic                   clk,
   input  logic                   i_rst,
   input  logic [NUM_CLIENTS-1:0] i_valid_candidate,
   output logic [NUM_CLIENTS-1:0] o_winner_dec_id
);

   localparam int PTR_W = (NUM_CLIENTS > 1) ? $clog2(NUM_CLIENTS) : 1;

   logic [PTR_W-1:0] ptr;          // first client searched this cycle
   logic [PTR_W-1:0] winner_idx;
   logic             granted;

   // search from the pointer upwards and wrap, the first candidate found wins
   always_comb begin
      int idx;
      o_winner_dec_id = '0;
      winner_idx      = '0;
      granted         = 1'b0;
      for (int k = 0; k < NUM_CLIENTS; k++) begin
         idx = (int'(ptr) + k) % NUM_CLIENTS;
         if (!granted && i_valid_candidate[idx]) begin
            o_winner_dec_id[idx] = 1'b1;
            winner_idx           = PTR_W'(idx);
            granted              = 1'b1;
         end
      end
   end

   // the pointer only moves on a grant, it stays put through idle cycles
   always_ff @(posedge clk) begin
      if (i_rst) begin
         ptr <= '0;
      end else if (granted) begin
         ptr <= (winner_idx == PTR_W'(NUM_CLIENTS - 1)) ? '0 : winner_idx + 1'b1;
      end
   end

endmodule

//--- verilog/sram.sv
// behavioural single-port SRAM with a busy cycle after writes and a pipelined fixed-latency read
`timescale 1ns/100ps

module sram (
   input  logic                                clk,
   input  logic                                i_rst,
   fm_req_if.receiver                          sram_req,
   output logic                                o_ready,
   output logic                                o_rsp_valid,
   output logic [mem_ss_param_pkg::ADDR_W-1:0] o_rsp_addr,
   output logic [mem_ss_param_pkg::DATA_W-1:0] o_rsp_data
);

   localparam int IDX_W = $clog2(mem_ss_param_pkg::SRAM_WORDS);
   localparam int LAT   = mem_ss_param_pkg::SRAM_RD_LAT;

   logic [mem_ss_param_pkg::DATA_W-1:0] mem [mem_ss_param_pkg::SRAM_WORDS];
   logic [IDX_W-1:0]                    idx;
   logic                                wr_acc;
   logic                                rd_acc;
   logic                                busy;
   logic [LAT-1:0]                      rd_vld;
   logic [mem_ss_param_pkg::ADDR_W-1:0] rd_addr [LAT];
   logic [mem_ss_param_pkg::DATA_W-1:0] rd_data [LAT];

   // bit 16 keeps the i and d halves apart, bits 6..0 pick the word inside a half
   assign idx = {sram_req.addr[16], sram_req.addr[6:0]};

   assign wr_acc  = sram_req.valid & (sram_req.write == mem_ss_req_pkg::OP_WRITE);
   assign rd_acc  = sram_req.valid & (sram_req.write == mem_ss_req_pkg::OP_READ);
   assign o_ready = ~busy;    // a write holds the array for a second cycle

   always_ff @(posedge clk) begin
      if (i_rst) begin
         busy   <= 1'b0;
         rd_vld <= '0;
      end else begin
         busy   <= wr_acc;
         rd_vld <= {rd_vld[LAT-2:0], rd_acc};
      end
   end

   // storage and the read payload stages are plain registers
   always_ff @(posedge clk) begin
      if (wr_acc) begin
         mem[idx] <= sram_req.data;
      end
      rd_addr[0] <= sram_req.addr;
      rd_data[0] <= mem[idx];
      for (int s = 1; s < LAT; s++) begin
         rd_addr[s] <= rd_addr[s-1];
         rd_data[s] <= rd_data[s-1];
      end
   end

   assign o_rsp_valid = rd_vld[LAT-1];
   assign o_rsp_addr  = rd_addr[LAT-1];
   assign o_rsp_data  = rd_data[LAT-1];

endmodule

//--- verilog/mc.sv
// memory controller: per-agent request FIFOs, round-robin pick onto the SRAM, read responses routed by address
`timescale 1ns/100ps

module mc (
   input  logic                                clk,
   input  logic                                i_rst,

   fm_req_if.receiver                          i_req,
   fm_req_if.receiver                          d_req,
   output logic                                o_i_ready,
   output logic                                o_d_ready,

   fm_req_if.sender                            sram_req,
   input  logic                                i_sram_ready,
   input  logic                                i_rsp_valid,
   input  logic [mem_ss_param_pkg::ADDR_W-1:0] i_rsp_addr,
   input  logic [mem_ss_param_pkg::DATA_W-1:0] i_rsp_data,

   output logic                                o_i_rsp_valid,
   output logic                                o_d_rsp_valid,
   output logic [mem_ss_param_pkg::ADDR_W-1:0] o_rsp_addr,
   output logic [mem_ss_param_pkg::DATA_W-1:0] o_rsp_data
);

   // one FIFO word is {write, addr, data}
   localparam int REQ_W = 1 + mem_ss_param_pkg::ADDR_W + mem_ss_param_pkg::DATA_W;

   logic [REQ_W-1:0]                      i_head;
   logic [REQ_W-1:0]                      d_head;
   logic [REQ_W-1:0]                      sel_head;
   logic                                  i_fifo_full;
   logic                                  d_fifo_full;
   logic                                  i_fifo_empty;
   logic                                  d_fifo_empty;
   logic [mem_ss_req_pkg::NUM_AGENTS-1:0] valid_candidate;
   logic [mem_ss_req_pkg::NUM_AGENTS-1:0] winner_dec_id;
   logic                                  rsp_in_i_range;
   logic                                  rsp_in_d_range;

   assign o_i_ready = ~i_fifo_full;    // agents back off while their queue is full
   assign o_d_ready = ~d_fifo_full;

   fifo #(.DATA_W(REQ_W), .DEPTH(mem_ss_param_pkg::FIFO_DEPTH)) i_mem_fifo_req (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_push      (i_req.valid),
      .i_push_data ({i_req.write, i_req.addr, i_req.data}),
      .i_pop       (winner_dec_id[mem_ss_req_pkg::AGENT_I]),
      .o_pop_data  (i_head),
      .o_full      (i_fifo_full),
      .o_empty     (i_fifo_empty)
   );

   fifo #(.DATA_W(REQ_W), .DEPTH(mem_ss_param_pkg::FIFO_DEPTH)) d_mem_fifo_req (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_push      (d_req.valid),
      .i_push_data ({d_req.write, d_req.addr, d_req.data}),
      .i_pop       (winner_dec_id[mem_ss_req_pkg::AGENT_D]),
      .o_pop_data  (d_head),
      .o_full      (d_fifo_full),
      .o_empty     (d_fifo_empty)
   );

   // nothing competes while the SRAM is busy, so both queues simply hold
   assign valid_candidate[mem_ss_req_pkg::AGENT_I] = ~i_fifo_empty & i_sram_ready;
   assign valid_candidate[mem_ss_req_pkg::AGENT_D] = ~d_fifo_empty & i_sram_ready;

   arbiter #(.NUM_CLIENTS(mem_ss_req_pkg::NUM_AGENTS)) rr_arb (
      .clk               (clk),
      .i_rst             (i_rst),
      .i_valid_candidate (valid_candidate),
      .o_winner_dec_id   (winner_dec_id)
   );

   // the winner's head goes out in the same cycle it is popped
   assign sel_head = winner_dec_id[mem_ss_req_pkg::AGENT_I] ? i_head :
                     winner_dec_id[mem_ss_req_pkg::AGENT_D] ? d_head : '0;

   assign sram_req.valid = |winner_dec_id;
   assign {sram_req.write, sram_req.addr, sram_req.data} = sel_head;

   // responses carry no source tag, the address range tells which agent asked
   assign rsp_in_i_range = (i_rsp_addr >= mem_ss_param_pkg::I_BASE) &&
                           (i_rsp_addr <  mem_ss_param_pkg::I_TOP);
   assign rsp_in_d_range = (i_rsp_addr >= mem_ss_param_pkg::D_BASE) &&
                           (i_rsp_addr <  mem_ss_param_pkg::D_TOP);

   assign o_i_rsp_valid = i_rsp_valid & rsp_in_i_range;
   assign o_d_rsp_valid = i_rsp_valid & rsp_in_d_range;    // out of both ranges reaches nobody
   assign o_rsp_addr    = i_rsp_addr;
   assign o_rsp_data    = i_rsp_data;

endmodule

//--- verilog/mem_ss.sv
// memory subsystem top: controller plus SRAM, with the request bundles opened up into plain ports
`timescale 1ns/100ps

module mem_ss (
   input  logic                                clk,
   input  logic                                i_rst,

   input  logic                                i_i_req_valid,
   input  logic                                i_i_req_write,
   input  logic [mem_ss_param_pkg::ADDR_W-1:0] i_i_req_addr,
   input  logic [mem_ss_param_pkg::DATA_W-1:0] i_i_req_data,
   output logic                                o_i_ready,

   input  logic                                i_d_req_valid,
   input  logic                                i_d_req_write,
   input  logic [mem_ss_param_pkg::ADDR_W-1:0] i_d_req_addr,
   input  logic [mem_ss_param_pkg::DATA_W-1:0] i_d_req_data,
   output logic                                o_d_ready,

   output logic                                o_i_rsp_valid,
   output logic                                o_d_rsp_valid,
   output logic [mem_ss_param_pkg::ADDR_W-1:0] o_rsp_addr,
   output logic [mem_ss_param_pkg::DATA_W-1:0] o_rsp_data
);

   fm_req_if i_req ();
   fm_req_if d_req ();
   fm_req_if sram_req ();

   logic                                sram_ready;
   logic                                sram_rsp_valid;
   logic [mem_ss_param_pkg::ADDR_W-1:0] sram_rsp_addr;
   logic [mem_ss_param_pkg::DATA_W-1:0] sram_rsp_data;

   // the top level acts as sender on both agent bundles
   assign i_req.valid = i_i_req_valid;
   assign i_req.write = i_i_req_write;
   assign i_req.addr  = i_i_req_addr;
   assign i_req.data  = i_i_req_data;

   assign d_req.valid = i_d_req_valid;
   assign d_req.write = i_d_req_write;
   assign d_req.addr  = i_d_req_addr;
   assign d_req.data  = i_d_req_data;

   mc u_mc (
      .clk           (clk),
      .i_rst         (i_rst),
      .i_req         (i_req.receiver),
      .d_req         (d_req.receiver),
      .o_i_ready     (o_i_ready),
      .o_d_ready     (o_d_ready),
      .sram_req      (sram_req.sender),
      .i_sram_ready  (sram_ready),
      .i_rsp_valid   (sram_rsp_valid),
      .i_rsp_addr    (sram_rsp_addr),
      .i_rsp_data    (sram_rsp_data),
      .o_i_rsp_valid (o_i_rsp_valid),
      .o_d_rsp_valid (o_d_rsp_valid),
      .o_rsp_addr    (o_rsp_addr),
      .o_rsp_data    (o_rsp_data)
   );

   sram u_sram (
      .clk         (clk),
      .i_rst       (i_rst),
      .sram_req    (sram_req.receiver),
      .o_ready     (sram_ready),
      .o_rsp_valid (sram_rsp_valid),
      .o_rsp_addr  (sram_rsp_addr),
      .o_rsp_data  (sram_rsp_data)
   );

endmodule

//--- dv/mem_ss_chk.sv
// protocol checker for the memory controller: one-hot grant, no request while busy, exclusive routing
`timescale 1ns/100ps

module mem_ss_chk (
   input logic                                  clk,
   input logic                                  i_rst,
   input logic [mem_ss_req_pkg::NUM_AGENTS-1:0] i_winner,
   input logic                                  i_sram_valid,
   input logic                                  i_sram_ready,
   input logic                                  i_i_rsp_valid,
   input logic                                  i_d_rsp_valid
);

   // at most one FIFO is popped per cycle
   a_winner_onehot: assert property (@(posedge clk) disable iff (i_rst) $onehot0(i_winner))
      else $error("arbiter winner %b is not one-hot or zero", i_winner);

   a_no_req_when_busy: assert property (@(posedge clk) disable iff (i_rst)
      !(i_sram_valid && !i_sram_ready))
      else $error("SRAM request valid while the SRAM is not ready");

   // the address ranges do not overlap, so a response has at most one owner
   a_rsp_exclusive: assert property (@(posedge clk) disable iff (i_rst)
      !(i_i_rsp_valid && i_d_rsp_valid))
      else $error("i and d response valids high in the same cycle");

endmodule

bind mc mem_ss_chk u_chk (
   .clk           (clk),
   .i_rst         (i_rst),
   .i_winner      (winner_dec_id),
   .i_sram_valid  (sram_req.valid),
   .i_sram_ready  (i_sram_ready),
   .i_i_rsp_valid (o_i_rsp_valid),
   .i_d_rsp_valid (o_d_rsp_valid)
);

//--- dv/mem_ss_tb.sv
// memory subsystem testbench with seeded random traffic checked against a shadow model
`timescale 1ns/100ps

module mem_ss_tb;

   localparam int AW         = mem_ss_param_pkg::ADDR_W;
   localparam int DW         = mem_ss_param_pkg::DATA_W;
   localparam int IW         = $clog2(mem_ss_param_pkg::SRAM_WORDS);
   localparam int AI         = mem_ss_req_pkg::AGENT_I;
   localparam int AD         = mem_ss_req_pkg::AGENT_D;
   localparam int NUM_TESTS  = 5;
   localparam int MAX_CYCLES = NUM_TESTS * 200 + 100;    // 200 per test plus reset and drain

   logic          clk;
   logic          i_rst;
   logic          i_i_req_valid;
   logic          i_i_req_write;
   logic [AW-1:0] i_i_req_addr;
   logic [DW-1:0] i_i_req_data;
   logic          o_i_ready;
   logic          i_d_req_valid;
   logic          i_d_req_write;
   logic [AW-1:0] i_d_req_addr;
   logic [DW-1:0] i_d_req_data;
   logic          o_d_ready;
   logic          o_i_rsp_valid;
   logic          o_d_rsp_valid;
   logic [AW-1:0] o_rsp_addr;
   logic [DW-1:0] o_rsp_data;

   integer           seed = 28;
   int               cycles = 0;
   int               errors = 0;
   int               err_at_start = 0;
   int               tests = 0;
   int               failed = 0;
   int               n_rsp = 0;      // responses seen in the current test
   int               n_exp = 0;      // routed reads issued in the current test
   int               total_rsp = 0;
   int               rr_ptr = 0;     // arbiter pointer as inferred from response order
   bit               rr_check = 0;
   logic [DW-1:0]    shadow [mem_ss_param_pkg::SRAM_WORDS];
   logic [AW+DW-1:0] exp_i [$];      // expected {addr, data} per destination agent
   logic [AW+DW-1:0] exp_d [$];

   mem_ss dut (.*);

   always #20 clk = ~clk;

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("ERROR: timeout, the run went past %0d cycles", MAX_CYCLES);
         $display("sim failed");
         $finish;
      end
   end

   // owner of an address by the map or -1 when it lies outside both ranges
   function automatic int dest_of(input logic [AW-1:0] addr);
      if (addr >= mem_ss_param_pkg::I_BASE && addr < mem_ss_param_pkg::I_TOP) return AI;
      if (addr >= mem_ss_param_pkg::D_BASE && addr < mem_ss_param_pkg::D_TOP) return AD;
      return -1;
   endfunction

   function automatic logic [AW-1:0] rand_addr(input int agent);
      logic [15:0] low;
      low = 16'($random(seed));
      return (agent == AI) ? mem_ss_param_pkg::I_BASE + AW'(low)
                           : mem_ss_param_pkg::D_BASE + AW'(low);
   endfunction

   function automatic logic ready_of(input int agent);
      return (agent == AI) ? o_i_ready : o_d_ready;
   endfunction

   task automatic take_rsp(input int agent);
      logic [AW+DW-1:0] exp;
      bit               have;
      n_rsp++;
      total_rsp++;
      assert (dest_of(o_rsp_addr) == agent) else begin
         $display("ERROR: response for address %h raised the valid of agent %0d",
                  o_rsp_addr, agent);
         errors++;
      end
      if (rr_check) begin
         assert (agent == rr_ptr) else begin
            $display("ERROR: round robin broken, agent %0d answered before agent %0d",
                     agent, rr_ptr);
            errors++;
         end
      end
      rr_ptr = (agent + 1) % mem_ss_req_pkg::NUM_AGENTS;    // grants are inferred from responses
      have = (agent == AI) ? (exp_i.size() > 0) : (exp_d.size() > 0);
      assert (have) else begin
         $display("ERROR: agent %0d got a response at %h with no read outstanding",
                  agent, o_rsp_addr);
         errors++;
      end
      if (have) begin
         exp = (agent == AI) ? exp_i.pop_front() : exp_d.pop_front();
         assert (o_rsp_addr == exp[AW+DW-1:DW]) else begin
            $display("MISMATCH o_rsp_addr: expected %h, got %h", exp[AW+DW-1:DW], o_rsp_addr);
            errors++;
         end
         assert (o_rsp_data == exp[DW-1:0]) else begin
            $display("MISMATCH o_rsp_data: expected %h, got %h", exp[DW-1:0], o_rsp_data);
            errors++;
         end
      end
   endtask

   // advance to the next falling edge, end any one-cycle request and check the responses
   task automatic step();
      @(negedge clk);
      i_i_req_valid = 1'b0;
      i_d_req_valid = 1'b0;
      assert (!(o_i_rsp_valid && o_d_rsp_valid)) else begin
         $display("ERROR: both response valids high for address %h", o_rsp_addr);
         errors++;
      end
      if (o_i_rsp_valid) take_rsp(AI);
      if (o_d_rsp_valid) take_rsp(AD);
   endtask

   // present one request this cycle and update the model as of issue time
   task automatic drive(input int agent, input logic wr, input logic [AW-1:0] addr,
                        input logic [DW-1:0] data);
      logic [IW-1:0] idx;
      idx = {addr[16], addr[6:0]};
      if (agent == AI) begin
         i_i_req_valid = 1'b1;
         i_i_req_write = wr;
         i_i_req_addr  = addr;
         i_i_req_data  = data;
      end else begin
         i_d_req_valid = 1'b1;
         i_d_req_write = wr;
         i_d_req_addr  = addr;
         i_d_req_data  = data;
      end
      if (wr == mem_ss_req_pkg::OP_WRITE) begin
         shadow[idx] = data;
      end else if (dest_of(addr) == AI) begin
         exp_i.push_back({addr, shadow[idx]});
         n_exp++;
      end else if (dest_of(addr) == AD) begin
         exp_d.push_back({addr, shadow[idx]});
         n_exp++;
      end    // out of range reads expect no response at all
   endtask

   task automatic push_req(input int agent, input logic wr, input logic [AW-1:0] addr,
                           input logic [DW-1:0] data);
      while (!ready_of(agent)) step();
      drive(agent, wr, addr, data);
      step();
   endtask

   task automatic drain();
      while (exp_i.size() != 0 || exp_d.size() != 0) step();
   endtask

   task automatic end_test(input string name);
      assert (n_rsp == n_exp) else begin
         $display("ERROR: %0d reads issued but %0d responses received", n_exp, n_rsp);
         errors++;
      end
      tests++;
      if (errors == err_at_start) begin
         $display("test %0d %s: ok", tests, name);
      end else begin
         failed++;
         $display("test %0d %s: FAILED with %0d errors", tests, name, errors - err_at_start);
      end
      err_at_start = errors;
      n_rsp = 0;
      n_exp = 0;
   endtask

   task automatic write_read(input int agent, input int n);
      logic [AW-1:0] addrs [$];
      logic [AW-1:0] a;
      for (int k = 0; k < n; k++) begin
         a = rand_addr(agent);
         addrs.push_back(a);
         push_req(agent, mem_ss_req_pkg::OP_WRITE, a, $random(seed));
      end
      while (addrs.size() != 0) push_req(agent, mem_ss_req_pkg::OP_READ, addrs.pop_back(), '0);
      drain();
   endtask

   task automatic route_test();
      logic [AW-1:0] oor;
      logic [AW-1:0] a_i;
      logic [AW-1:0] a_d;
      logic [15:0]   low;
      low = 16'($random(seed));
      oor = mem_ss_param_pkg::D_TOP + AW'(low);    // aliases an i half word in the SRAM
      a_i = rand_addr(AI);
      a_d = rand_addr(AD);
      push_req(AI, mem_ss_req_pkg::OP_WRITE, mem_ss_param_pkg::I_BASE + AW'(low), $random(seed));
      push_req(AI, mem_ss_req_pkg::OP_WRITE, a_i, $random(seed));
      push_req(AD, mem_ss_req_pkg::OP_WRITE, a_d, $random(seed));
      push_req(AI, mem_ss_req_pkg::OP_READ, oor, '0);
      push_req(AI, mem_ss_req_pkg::OP_READ, a_i, '0);    // arrives only after the silent one
      push_req(AD, mem_ss_req_pkg::OP_READ, a_d, '0);
      drain();
   endtask

   task automatic rr_test();
      logic [AW-1:0] ai [4];
      logic [AW-1:0] ad [4];
      for (int k = 0; k < 4; k++) begin
         ai[k] = rand_addr(AI);
         ad[k] = rand_addr(AD);
         push_req(AI, mem_ss_req_pkg::OP_WRITE, ai[k], $random(seed));
         push_req(AD, mem_ss_req_pkg::OP_WRITE, ad[k], $random(seed));
      end
      // the last grant before the idle gap is a d read, so the pointer rests on i
      push_req(AI, mem_ss_req_pkg::OP_READ, ai[0], '0);
      drain();
      push_req(AD, mem_ss_req_pkg::OP_READ, ad[0], '0);
      drain();
      rr_check = 1'b1;
      for (int k = 0; k < 4; k++) begin
         while (!(o_i_ready && o_d_ready)) step();
         drive(AI, mem_ss_req_pkg::OP_READ, ai[k], '0);
         drive(AD, mem_ss_req_pkg::OP_READ, ad[k], '0);
         step();
      end
      drain();
      rr_check = 1'b0;
   endtask

   task automatic backpressure_test();
      logic [AW-1:0] wi [$];
      logic [AW-1:0] wd [$];
      logic [AW-1:0] a;
      bit            saw_bp;
      saw_bp = 1'b0;
      repeat (20) begin
         if (!o_i_ready || !o_d_ready) saw_bp = 1'b1;
         if (o_i_ready) begin
            a = rand_addr(AI);
            wi.push_back(a);
            drive(AI, mem_ss_req_pkg::OP_WRITE, a, $random(seed));
         end
         if (o_d_ready) begin
            a = rand_addr(AD);
            wd.push_back(a);
            drive(AD, mem_ss_req_pkg::OP_WRITE, a, $random(seed));
         end
         step();
      end
      assert (saw_bp) else begin
         $display("ERROR: neither ready went low under a full write load");
         errors++;
      end
      while (wi.size() != 0 || wd.size() != 0) begin
         if (o_i_ready && wi.size() != 0) drive(AI, mem_ss_req_pkg::OP_READ, wi.pop_front(), '0);
         if (o_d_ready && wd.size() != 0) drive(AD, mem_ss_req_pkg::OP_READ, wd.pop_front(), '0);
         step();
      end
      drain();
   endtask

   initial begin
      clk           = 1'b0;
      i_rst         = 1'b1;
      i_i_req_valid = 1'b0;
      i_i_req_write = 1'b0;
      i_i_req_addr  = '0;
      i_i_req_data  = '0;
      i_d_req_valid = 1'b0;
      i_d_req_write = 1'b0;
      i_d_req_addr  = '0;
      i_d_req_data  = '0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      i_rst = 1'b0;

      write_read(AI, 12);
      end_test("i side write then read");
      write_read(AD, 12);
      end_test("d side write then read");
      route_test();
      end_test("routing by address range");
      rr_test();
      end_test("round robin order");
      backpressure_test();
      end_test("back-pressure without loss");

      $display("tests run %0d, tests failed %0d, errors %0d, responses checked %0d",
               tests, failed, errors, total_rsp);
      if (errors == 0 && failed == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

//--- tb.f
verilog/mem_ss_param_pkg.sv
verilog/mem_ss_req_pkg.sv
verilog/fm_req_if.sv
verilog/fifo.sv
verilog/arbiter.sv
verilog/sram.sv
verilog/mc.sv
verilog/mem_ss.sv
dv/mem_ss_chk.sv
dv/mem_ss_tb.sv
